// ==== Makefile ====
# Verilator build and run for the GCD farm testbench.

TOP := tb_gcd_farm

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf obj_dir

// ==== build.f ====
design/gcd_pkg.sv
design/gcd_job_if.sv
design/gcd_res_if.sv
design/gcd_dispatch.sv
design/gcd_lane.sv
design/reorder.sv
design/gcd_farm.sv
test/tb_gcd_farm.sv

// ==== design/gcd_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module gcd_dispatch (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            in_vld,
    input  wire [gcd_pkg::OPERAND_W-1:0]   in_a,
    input  wire [gcd_pkg::OPERAND_W-1:0]   in_b,
    output logic                           in_ready,
    gcd_job_if.dispatch                    jobs  [gcd_pkg::N_LANES],
    gcd_res_if.buffer                      slots [gcd_pkg::N_LANES]
);

    logic [gcd_pkg::LANE_W-1:0]    ptr;
    logic [gcd_pkg::N_LANES-1:0]   idle;
    logic [gcd_pkg::N_LANES-1:0]   slot_free;
    logic [gcd_pkg::N_LANES-1:0]   start_q;
    logic [gcd_pkg::OPERAND_W-1:0] a_q;
    logic [gcd_pkg::OPERAND_W-1:0] b_q;
    logic                          accept;

    // Flatten the per-lane views and fan the operands out.
    for (genvar g = 0; g < gcd_pkg::N_LANES; g++) begin : g_lane
        assign idle[g]        = jobs[g].idle;
        assign slot_free[g]   = slots[g].slot_free;
        assign jobs[g].start  = start_q[g];
        assign jobs[g].a      = a_q;
        assign jobs[g].b      = b_q;

        // The lane must still be idle when its start strobe shows up.
        a_start_idle: assert property (
            @(posedge clk) disable iff (rst) start_q[g] |-> idle[g]
        );
    end

    // Target lane must be idle and have room for its result.
    assign in_ready = idle[ptr] & slot_free[ptr];
    assign accept   = in_vld & in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr     <= '0;
            start_q <= '0;
        end else begin
            start_q <= '0;
            if (accept) begin
                start_q[ptr] <= 1'b1;
                // Strict turn order keeps lane order equal to job order.
                if (ptr == gcd_pkg::LAST_LANE) begin
                    ptr <= '0;
                end else begin
                    ptr <= ptr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= in_a;
            b_q <= in_b;
        end
    end

endmodule

`default_nettype wire

// ==== design/gcd_farm.sv ====
`timescale 1ns/1ps
`default_nettype none

module gcd_farm (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            in_vld,
    input  wire [gcd_pkg::OPERAND_W-1:0]   in_a,
    input  wire [gcd_pkg::OPERAND_W-1:0]   in_b,
    output logic                           in_ready,
    output logic                           out_vld,
    output logic [gcd_pkg::OPERAND_W-1:0]  out_value,
    output logic [gcd_pkg::STEPS_W-1:0]    out_steps
);

    gcd_pkg::gcd_result_t down_data;

    // One job bus and one result bus per lane.
    gcd_job_if job_bus [gcd_pkg::N_LANES] ();
    gcd_res_if res_bus [gcd_pkg::N_LANES] ();

    gcd_dispatch i_dispatch (
        .clk      (clk),
        .rst      (rst),
        .in_vld   (in_vld),
        .in_a     (in_a),
        .in_b     (in_b),
        .in_ready (in_ready),
        .jobs     (job_bus),
        .slots    (res_bus)
    );

    for (genvar g = 0; g < gcd_pkg::N_LANES; g++) begin : g_lane
        gcd_lane i_lane (
            .clk (clk),
            .rst (rst),
            .job (job_bus[g]),
            .res (res_bus[g])
        );
    end

    // Puts results back into dispatch order.
    reorder #(
        .payload_t (gcd_pkg::gcd_result_t),
        .n_inputs  (gcd_pkg::N_LANES)
    ) i_reorder (
        .clk       (clk),
        .rst       (rst),
        .ups       (res_bus),
        .down_vld  (out_vld),
        .down_data (down_data)
    );

    assign out_value = down_data.value;
    assign out_steps = down_data.steps;

endmodule

`default_nettype wire

// ==== design/gcd_job_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface gcd_job_if;

    // One-cycle job strobe, only while idle is high.
    logic                          start;
    logic [gcd_pkg::OPERAND_W-1:0] a;
    logic [gcd_pkg::OPERAND_W-1:0] b;

    // Lane can take a new job.
    logic                          idle;

    modport dispatch (
        output start,
        output a,
        output b,
        input  idle
    );

    modport lane (
        input  start,
        input  a,
        input  b,
        output idle
    );

endinterface

`default_nettype wire

// ==== design/gcd_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module gcd_lane (
    input  wire     clk,
    input  wire     rst,
    gcd_job_if.lane job,
    gcd_res_if.lane res
);

    logic                          busy;
    logic [gcd_pkg::OPERAND_W-1:0] x;
    logic [gcd_pkg::OPERAND_W-1:0] y;
    logic [gcd_pkg::STEPS_W-1:0]   steps;
    logic                          finished;
    logic                          done;
    gcd_pkg::gcd_result_t          result;

    // Stop on equal operands or when either one hits zero.
    assign finished = (x == y) || (x == '0) || (y == '0);

    // Done sits in the last busy cycle, so idle returns one cycle later.
    assign done     = busy & finished;
    assign job.idle = ~busy;

    always_comb begin
        // Zero in x means y holds the answer, which also covers gcd(0,0).
        result.value = (x == '0) ? y : x;
        result.steps = steps;
    end

    assign res.done   = done;
    assign res.result = result;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (job.start) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    // Operand registers and step counter.
    always_ff @(posedge clk) begin
        if (job.start) begin
            x     <= job.a;
            y     <= job.b;
            steps <= '0;
        end else if (busy && !finished) begin
            if (x > y) begin
                x <= x - y;
            end else begin
                y <= y - x;
            end
            steps <= steps + 1'b1;
        end
    end

    a_done_single: assert property (
        @(posedge clk) disable iff (rst) done |=> !done
    );

    // The dispatcher must not hand over a job mid-computation.
    a_start_not_busy: assert property (
        @(posedge clk) disable iff (rst) job.start |-> !busy
    );

endmodule

`default_nettype wire

// ==== design/gcd_pkg.sv ====
`default_nettype none

package gcd_pkg;

    // Operand and result width.
    localparam int OPERAND_W = 8;

    // Width of the subtraction step counter.
    localparam int STEPS_W = 8;

    // Number of GCD lanes running side by side.
    localparam int N_LANES = 2;

    // Lane index width, never below one bit.
    localparam int LANE_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

    // Index of the last lane, where the dispatch pointer wraps.
    localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(N_LANES - 1);

    // One finished job as it leaves a lane.
    typedef struct packed {
        logic [OPERAND_W-1:0] value;
        logic [STEPS_W-1:0]   steps;
    } gcd_result_t;

endpackage

`default_nettype wire

// ==== design/gcd_res_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface gcd_res_if;

    // One-cycle strobe, result is valid with it.
    logic                 done;
    gcd_pkg::gcd_result_t result;

    // Latch for this lane is empty or being drained now.
    logic                 slot_free;

    modport lane (
        output done,
        output result
    );

    // The dispatcher also takes this view to read slot_free.
    modport buffer (
        input  done,
        input  result,
        output slot_free
    );

endinterface

`default_nettype wire

// ==== design/reorder.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder #(
    parameter type payload_t = gcd_pkg::gcd_result_t,
    parameter int  n_inputs  = gcd_pkg::N_LANES
) (
    input  wire       clk,
    input  wire       rst,
    gcd_res_if.buffer ups [n_inputs],
    output logic      down_vld,
    output payload_t  down_data
);

    logic [n_inputs-1:0]         up_done;
    payload_t                    up_data    [n_inputs];
    payload_t                    data_latch [n_inputs];
    logic [n_inputs-1:0]         vld_latch;
    logic [n_inputs-1:0]         ring;
    logic [n_inputs-1:0]         drain_hot;
    logic [$clog2(n_inputs)-1:0] ptr;

    // One-hot view of the latch that is leaving this cycle.
    assign drain_hot = ring & {n_inputs{down_vld}};

    for (genvar i = 0; i < n_inputs; i++) begin : g_in
        assign up_done[i]       = ups[i].done;
        assign up_data[i]       = ups[i].result;
        assign ups[i].slot_free = ~vld_latch[i] | drain_hot[i];

        // The dispatcher only starts a lane whose slot is free.
        a_no_overwrite: assert property (
            @(posedge clk) disable iff (rst)
            up_done[i] |-> (!vld_latch[i] || drain_hot[i])
        );
    end

    // Valid bits. A new done wins over the drain of the same slot.
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_latch <= '0;
        end else begin
            for (int i = 0; i < n_inputs; i++) begin
                if (up_done[i]) begin
                    vld_latch[i] <= 1'b1;
                end else if (drain_hot[i]) begin
                    vld_latch[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < n_inputs; i++) begin
            if (up_done[i]) begin
                data_latch[i] <= up_data[i];
            end
        end
    end

    // Expected lane ring, rotated once per released result.
    always_ff @(posedge clk) begin
        if (rst) begin
            ring    <= '0;
            ring[0] <= 1'b1;
        end else if (down_vld) begin
            ring <= {ring[n_inputs-2:0], ring[n_inputs-1]};
        end
    end

    // One-hot to index.
    always_comb begin
        ptr = '0;
        for (int i = 0; i < n_inputs; i++) begin
            if (ring[i]) begin
                ptr = i[$clog2(n_inputs)-1:0];
            end
        end
    end

    assign down_vld  = vld_latch[ptr];
    assign down_data = data_latch[ptr];

    a_ring_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot(ring)
    );

endmodule

`default_nettype wire

// ==== test/tb_gcd_farm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gcd_farm;

    localparam int READY_TIMEOUT = 2000;
    localparam int RANDOM_JOBS   = 300;
    localparam int RANDOM_CYCLES = 40000;
    localparam int DRAIN_TIMEOUT = 4000;

    logic                          clk;
    logic                          rst;
    logic                          in_vld;
    logic [gcd_pkg::OPERAND_W-1:0] in_a;
    logic [gcd_pkg::OPERAND_W-1:0] in_b;
    logic                          in_ready;
    logic                          out_vld;
    logic [gcd_pkg::OPERAND_W-1:0] out_value;
    logic [gcd_pkg::STEPS_W-1:0]   out_steps;

    integer                        seed;
    int                            error_count;
    int                            timeout_count;
    int                            jobs_accepted;
    int                            results_seen;
    int                            ignored_strobes;
    gcd_pkg::gcd_result_t          model_q [$];
    gcd_pkg::gcd_result_t          got;
    gcd_pkg::gcd_result_t          exp_res;

    gcd_farm i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_vld    (in_vld),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_ready  (in_ready),
        .out_vld   (out_vld),
        .out_value (out_value),
        .out_steps (out_steps)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Euclid by division gives the value.
    // Subtraction needs one step less than the quotient sum, none with a zero operand.
    function automatic gcd_pkg::gcd_result_t expected_result(
        input logic [gcd_pkg::OPERAND_W-1:0] a,
        input logic [gcd_pkg::OPERAND_W-1:0] b
    );
        int                   x;
        int                   y;
        int                   r;
        int                   quotients;
        int                   n;
        gcd_pkg::gcd_result_t res;
        x         = a;
        y         = b;
        quotients = 0;
        while (y != 0) begin
            quotients = quotients + x / y;
            r = x % y;
            x = y;
            y = r;
        end
        if (a == 0 || b == 0) begin
            n = 0;
        end else begin
            n = quotients - 1;
        end
        res.value = x[gcd_pkg::OPERAND_W-1:0];
        res.steps = n[gcd_pkg::STEPS_W-1:0];
        return res;
    endfunction

    task automatic check_result(
        input gcd_pkg::gcd_result_t actual,
        input gcd_pkg::gcd_result_t expected,
        input string                what
    );
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s, got value %0d steps %0d, expected value %0d steps %0d",
                     $time, what, actual.value, actual.steps, expected.value, expected.steps);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // Mostly small operands, with zero and equal pairs mixed in.
    task automatic pick_operands(
        output logic [gcd_pkg::OPERAND_W-1:0] a,
        output logic [gcd_pkg::OPERAND_W-1:0] b
    );
        logic [31:0] r;
        r = $random(seed);
        case (r[3:0])
            4'd0: begin
                a = 8'd0;
                b = r[15:8];
            end
            4'd1: begin
                a = r[15:8];
                b = 8'd0;
            end
            4'd2: begin
                a = r[15:8];
                b = r[15:8];
            end
            4'd3: begin
                a = r[15:8];
                b = r[23:16];
            end
            4'd4: begin
                a = 8'd0;
                b = 8'd0;
            end
            default: begin
                a = {3'b000, r[12:8]};
                b = {3'b000, r[20:16]};
            end
        endcase
    endtask

    // Called just after a rising edge, returns just after the accepting edge.
    task automatic send_job(
        input logic [gcd_pkg::OPERAND_W-1:0] a,
        input logic [gcd_pkg::OPERAND_W-1:0] b
    );
        int   waited;
        logic seen;
        waited = 0;
        in_vld = 1'b1;
        in_a   = a;
        in_b   = b;
        @(negedge clk);
        seen = in_ready;
        while (!seen && waited < READY_TIMEOUT) begin
            @(negedge clk);
            seen = in_ready;
            waited++;
        end
        @(posedge clk);
        #2;
        in_vld = 1'b0;
        if (!seen) begin
            timeout_count++;
            $display("Timeout at %0t ns: in_ready never rose for job %0d, %0d", $time, a, b);
        end
    endtask

    // Model side. Pop before push so a job is never matched with itself.
    always @(negedge clk) begin
        if (!rst) begin
            if (out_vld) begin
                results_seen++;
                got.value = out_value;
                got.steps = out_steps;
                if (model_q.size() == 0) begin
                    error_count++;
                    $display("Unexpected result at %0t ns with no accepted job outstanding",
                             $time);
                end else begin
                    exp_res = model_q.pop_front();
                    check_result(got, exp_res, "result in dispatch order");
                end
            end
            if (in_vld && in_ready) begin
                model_q.push_back(expected_result(in_a, in_b));
                jobs_accepted++;
            end else if (in_vld) begin
                ignored_strobes++;
            end
        end
    end

    initial begin
        int                            cycles;
        logic [31:0]                   r;
        logic [gcd_pkg::OPERAND_W-1:0] a;
        logic [gcd_pkg::OPERAND_W-1:0] b;
        seed            = 32'hb040_edfb;
        error_count     = 0;
        timeout_count   = 0;
        jobs_accepted   = 0;
        results_seen    = 0;
        ignored_strobes = 0;
        rst    = 1'b1;
        in_vld = 1'b0;
        in_a   = '0;
        in_b   = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        @(negedge clk);
        check_flag(in_ready, 1'b1, "in_ready after reset");
        check_flag(out_vld, 1'b0, "out_vld after reset");
        @(posedge clk);
        #2;

        // Long job on lane 0, then a one-cycle job on lane 1.
        send_job(8'd255, 8'd1);
        send_job(8'd6, 8'd6);

        // Lane 0 is still busy, so these strobes must be ignored.
        in_vld = 1'b1;
        in_a   = 8'd9;
        in_b   = 8'd3;
        repeat (20) begin
            @(negedge clk);
            check_flag(in_ready, 1'b0, "in_ready while lane 0 is busy");
        end
        @(posedge clk);
        #2;
        in_vld = 1'b0;

        cycles = 0;
        while (jobs_accepted < RANDOM_JOBS + 2 && cycles < RANDOM_CYCLES) begin
            r = $random(seed);
            pick_operands(a, b);
            in_vld = (r % 100) < 70;
            in_a   = a;
            in_b   = b;
            @(posedge clk);
            #2;
            cycles++;
        end
        in_vld = 1'b0;
        if (jobs_accepted < RANDOM_JOBS + 2) begin
            timeout_count++;
            $display("Timeout at %0t ns: only %0d jobs were accepted", $time, jobs_accepted);
        end

        cycles = 0;
        while (model_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (model_q.size() != 0) begin
            timeout_count++;
            $display("Timeout at %0t ns: results stopped arriving, %0d still missing",
                     $time, model_q.size());
        end

        repeat (20) begin
            @(negedge clk);
            check_flag(out_vld, 1'b0, "out_vld after drain");
        end
        if (results_seen != jobs_accepted) begin
            error_count++;
            $display("Result count %0d does not match accepted job count %0d",
                     results_seen, jobs_accepted);
        end

        $display("Jobs %0d, results %0d, ignored strobes %0d, errors %0d, timeouts %0d",
                 jobs_accepted, results_seen, ignored_strobes, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
